/* rtl/cmd_pkg.sv */
`default_nettype none

package cmd_pkg;

	localparam int BUF_DEPTH = 256;
	localparam int BUF_AW = 8;
	localparam int CMD_W = 16;
	localparam int CNT_W = BUF_AW + 1; // Counts 0 to BUF_DEPTH inclusive
	localparam int NUM_REGS = 8;
	localparam int REG_W = 8;
	localparam int AXI_AW = 12;
	localparam int AXI_DW = 32;

	// Register map offsets
	localparam logic [AXI_AW-1:0] ADDR_CTRL = 12'h000;
	localparam logic [AXI_AW-1:0] ADDR_START = 12'h004;
	localparam logic [AXI_AW-1:0] ADDR_COUNT = 12'h008;
	localparam logic [AXI_AW-1:0] ADDR_STATUS = 12'h00C;
	localparam logic [AXI_AW-1:0] ADDR_REGS = 12'h020;
	localparam logic [AXI_AW-1:0] ADDR_BUF = 12'h800;

	localparam int MAX_LOAD_IMM = 10; // Largest immediate a load accepts

	typedef enum logic [7:0] {
		op_load = 8'd0,
		op_clear = 8'd1,
		op_add = 8'd2,
		op_halt = 8'd3
	} opcode_e;

	typedef enum logic [1:0] {
		err_none = 2'd0,
		err_opcode = 2'd1,
		err_range = 2'd2
	} cmd_err_e;

	typedef enum logic [1:0] {
		fs_idle = 2'd0,
		fs_read = 2'd1,
		fs_check = 2'd2,
		fs_end = 2'd3
	} fetch_state_e;

	// Field order matches the command word, opcode in the top byte
	typedef struct packed {
		opcode_e op;
		logic [2:0] arg1;
		logic [4:0] arg2;
	} cmd_t;

	typedef logic [NUM_REGS-1:0][REG_W-1:0] regfile_t;

endpackage

`default_nettype wire

/* rtl/cmd_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_buffer
	import cmd_pkg::*;
(
	input wire logic clk,
	input wire logic we,
	input wire logic [BUF_AW-1:0] waddr,
	input wire logic [CMD_W-1:0] wdata,
	input wire logic rd_en,
	input wire logic [BUF_AW-1:0] rd_addr,
	output logic [CMD_W-1:0] rd_data
);

	logic [CMD_W-1:0] mem [BUF_DEPTH];

	always_ff @(posedge clk)
	begin
		if (we)
			mem[waddr] <= wdata;
	end

	// Read data holds between fetches
	always_ff @(posedge clk)
	begin
		if (rd_en)
			rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

/* rtl/cmd_fetch_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_fetch_fsm
	import cmd_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic ptr_load,
	input wire logic [BUF_AW-1:0] start_addr,
	input wire logic fetch_start,
	input wire logic [CMD_W-1:0] rd_data,
	output logic rd_en,
	output logic [BUF_AW-1:0] rd_addr,
	output logic fetch_done,
	output cmd_t cmd,
	output cmd_err_e cmd_err
);

	fetch_state_e state;
	logic [BUF_AW-1:0] ptr;
	cmd_t raw;
	cmd_t dec_cmd;
	cmd_err_e dec_err;

	assign raw = cmd_t'(rd_data);
	assign rd_en = (state == fs_read);
	assign rd_addr = ptr;
	assign fetch_done = (state == fs_end);

	// Opcode table with argument masking per command
	always_comb
	begin
		dec_cmd = raw;
		dec_err = err_none;
		case (raw.op)
			op_load:
			begin
				if (raw.arg2 > MAX_LOAD_IMM)
					dec_err = err_range;
			end
			op_clear: dec_cmd.arg2 = '0;
			op_add: dec_cmd = raw;
			op_halt:
			begin
				dec_cmd.arg1 = '0;
				dec_cmd.arg2 = '0;
			end
			default: dec_err = err_opcode;
		endcase
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= fs_idle;
			ptr <= '0;
			cmd_err <= err_none;
		end
		else
		begin
			case (state)
				fs_idle:
				begin
					if (fetch_start)
						state <= fs_read;
				end
				fs_read:
				begin
					state <= fs_check;
					ptr <= ptr + 1'b1; // Wraps at the end of the buffer
				end
				fs_check:
				begin
					state <= fs_end;
					cmd_err <= dec_err;
				end
				fs_end: state <= fs_idle;
			endcase
			if (ptr_load)
				ptr <= start_addr;
		end
	end

	// A bad word leaves the last good command in place
	always_ff @(posedge clk)
	begin
		if (state == fs_check && dec_err == err_none)
			cmd <= dec_cmd;
	end

endmodule

`default_nettype wire

/* rtl/cmd_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_sequencer
	import cmd_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic run_start,
	input wire logic [CNT_W-1:0] cmd_count,
	input wire logic fetch_done,
	input wire cmd_t cmd,
	input wire cmd_err_e cmd_err,
	output logic ptr_load,
	output logic fetch_start,
	output logic busy,
	output logic done,
	output cmd_err_e run_err,
	output logic [CNT_W-1:0] exec_count,
	output regfile_t regs
);

	logic [CNT_W-1:0] run_count;
	logic [CNT_W-1:0] next_count;
	logic exec_valid;

	assign ptr_load = run_start;
	assign next_count = exec_count + 1'b1;
	assign exec_valid = busy && fetch_done && (cmd_err == err_none);

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			busy <= 1'b0;
			done <= 1'b0;
			fetch_start <= 1'b0;
			exec_count <= '0;
			run_err <= err_none;
			run_count <= '0;
		end
		else
		begin
			fetch_start <= 1'b0;
			if (run_start)
			begin
				run_count <= cmd_count; // Host may rewrite COUNT during the run
				exec_count <= '0;
				run_err <= err_none;
				if (cmd_count == '0)
				begin
					busy <= 1'b0;
					done <= 1'b1;
				end
				else
				begin
					busy <= 1'b1;
					done <= 1'b0;
					fetch_start <= 1'b1;
				end
			end
			else if (busy && fetch_done)
			begin
				if (cmd_err != err_none)
				begin
					run_err <= cmd_err; // First error stops the run
					busy <= 1'b0;
					done <= 1'b1;
				end
				else
				begin
					exec_count <= next_count;
					if (cmd.op == op_halt || next_count == run_count)
					begin
						busy <= 1'b0;
						done <= 1'b1;
					end
					else
						fetch_start <= 1'b1;
				end
			end
		end
	end

	// Register contents survive from one run to the next
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			regs <= '0;
		else if (exec_valid)
		begin
			case (cmd.op)
				op_load: regs[cmd.arg1] <= REG_W'(cmd.arg2);
				op_clear: regs[cmd.arg1] <= '0;
				op_add: regs[cmd.arg1] <= regs[cmd.arg1] + REG_W'(cmd.arg2); // Wraps mod 256
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/axil_cmd_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_cmd_regs
	import cmd_pkg::*;
(
	input wire logic clk,
	input wire logic rst,

	input wire logic [AXI_AW-1:0] awaddr,
	input wire logic awvalid,
	output logic awready,
	input wire logic [AXI_DW-1:0] wdata,
	input wire logic wvalid,
	output logic wready,
	output logic bvalid,
	output logic [1:0] bresp,
	input wire logic bready,
	input wire logic [AXI_AW-1:0] araddr,
	input wire logic arvalid,
	output logic arready,
	output logic rvalid,
	output logic [AXI_DW-1:0] rdata,
	output logic [1:0] rresp,
	input wire logic rready,

	output logic buf_we,
	output logic [BUF_AW-1:0] buf_waddr,
	output logic [CMD_W-1:0] buf_wdata,

	output logic run_start,
	output logic [BUF_AW-1:0] start_addr,
	output logic [CNT_W-1:0] cmd_count,
	input wire logic busy,
	input wire logic done,
	input wire cmd_err_e run_err,
	input wire logic [CNT_W-1:0] exec_count,
	input wire regfile_t regs
);

	logic wr_take;
	logic rd_take;
	logic wr_buf;
	logic [AXI_DW-1:0] rd_mux;

	// One write and one read in flight at most
	assign wr_take = awvalid && wvalid && !bvalid;
	assign rd_take = arvalid && !rvalid;
	assign awready = wr_take;
	assign wready = wr_take;
	assign arready = rd_take;
	assign bresp = 2'b00;
	assign rresp = 2'b00;

	// Buffer window spans 0x800 to 0xBFC
	assign wr_buf = (awaddr[AXI_AW-1:BUF_AW+2] == ADDR_BUF[AXI_AW-1:BUF_AW+2]);
	assign buf_we = wr_take && wr_buf;
	assign buf_waddr = awaddr[BUF_AW+1:2];
	assign buf_wdata = wdata[CMD_W-1:0];

	assign run_start = wr_take && (awaddr == ADDR_CTRL) && wdata[0] && !busy;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			bvalid <= 1'b0;
			start_addr <= '0;
			cmd_count <= '0;
		end
		else
		begin
			if (wr_take)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;

			if (wr_take && awaddr == ADDR_START)
				start_addr <= wdata[BUF_AW-1:0];
			if (wr_take && awaddr == ADDR_COUNT)
				cmd_count <= wdata[CNT_W-1:0];
		end
	end

	always_comb
	begin
		rd_mux = '0;
		if (araddr[AXI_AW-1:5] == ADDR_REGS[AXI_AW-1:5])
			rd_mux = {{(AXI_DW-REG_W){1'b0}}, regs[araddr[4:2]]};
		else
		begin
			case (araddr)
				ADDR_START: rd_mux = {{(AXI_DW-BUF_AW){1'b0}}, start_addr};
				ADDR_COUNT: rd_mux = {{(AXI_DW-CNT_W){1'b0}}, cmd_count};
				ADDR_STATUS: rd_mux = {{(AXI_DW-CNT_W-8){1'b0}}, exec_count, 4'b0000,
					run_err, done, busy};
				default: rd_mux = '0; // CTRL and the buffer are write only
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			rvalid <= 1'b0;
		else if (rd_take)
			rvalid <= 1'b1;
		else if (rready)
			rvalid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (rd_take)
			rdata <= rd_mux; // Held while rvalid waits on rready
	end

endmodule

`default_nettype wire

/* rtl/cmd_proc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_proc_top
	import cmd_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic [AXI_AW-1:0] awaddr,
	input wire logic awvalid,
	output logic awready,
	input wire logic [AXI_DW-1:0] wdata,
	input wire logic wvalid,
	output logic wready,
	output logic bvalid,
	output logic [1:0] bresp,
	input wire logic bready,
	input wire logic [AXI_AW-1:0] araddr,
	input wire logic arvalid,
	output logic arready,
	output logic rvalid,
	output logic [AXI_DW-1:0] rdata,
	output logic [1:0] rresp,
	input wire logic rready
);

	logic buf_we;
	logic [BUF_AW-1:0] buf_waddr;
	logic [CMD_W-1:0] buf_wdata;
	logic run_start;
	logic [BUF_AW-1:0] start_addr;
	logic [CNT_W-1:0] cmd_count;
	logic busy;
	logic done;
	cmd_err_e run_err;
	logic [CNT_W-1:0] exec_count;
	regfile_t regs;
	logic ptr_load;
	logic fetch_start;
	logic fetch_done;
	cmd_t cmd;
	cmd_err_e cmd_err;
	logic rd_en;
	logic [BUF_AW-1:0] rd_addr;
	logic [CMD_W-1:0] rd_data;

	axil_cmd_regs u_axil_cmd_regs (
		.clk(clk), .rst(rst),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bvalid(bvalid), .bresp(bresp), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready),
		.buf_we(buf_we), .buf_waddr(buf_waddr), .buf_wdata(buf_wdata),
		.run_start(run_start), .start_addr(start_addr), .cmd_count(cmd_count),
		.busy(busy), .done(done), .run_err(run_err),
		.exec_count(exec_count), .regs(regs)
	);

	cmd_buffer u_cmd_buffer (
		.clk(clk),
		.we(buf_we), .waddr(buf_waddr), .wdata(buf_wdata),
		.rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data)
	);

	cmd_fetch_fsm u_cmd_fetch_fsm (
		.clk(clk), .rst(rst),
		.ptr_load(ptr_load), .start_addr(start_addr),
		.fetch_start(fetch_start), .rd_data(rd_data),
		.rd_en(rd_en), .rd_addr(rd_addr),
		.fetch_done(fetch_done), .cmd(cmd), .cmd_err(cmd_err)
	);

	cmd_sequencer u_cmd_sequencer (
		.clk(clk), .rst(rst),
		.run_start(run_start), .cmd_count(cmd_count),
		.fetch_done(fetch_done), .cmd(cmd), .cmd_err(cmd_err),
		.ptr_load(ptr_load), .fetch_start(fetch_start),
		.busy(busy), .done(done), .run_err(run_err),
		.exec_count(exec_count), .regs(regs)
	);

endmodule

`default_nettype wire

/* test/cmd_proc_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_proc_sva
	import cmd_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic fetch_start,
	input wire logic fetch_done,
	input wire logic rd_en,
	input wire logic busy,
	input wire logic done,
	input wire cmd_err_e cmd_err,
	input wire logic rvalid,
	input wire logic rready,
	input wire logic [AXI_DW-1:0] rdata
);

	int err_count = 0;

	// A fetch request is answered exactly three cycles later
	fetch_latency: assert property (@(posedge clk) disable iff (!rst)
		fetch_start |-> ##3 fetch_done)
	else
	begin
		$error("fetch_done did not follow fetch_start after three cycles");
		err_count++;
	end

	done_origin: assert property (@(posedge clk) disable iff (!rst)
		fetch_done |-> $past(fetch_start, 3))
	else
	begin
		$error("fetch_done without a fetch_start three cycles earlier");
		err_count++;
	end

	read_slot: assert property (@(posedge clk) disable iff (!rst)
		rd_en |-> $past(fetch_start)) // Buffer is read only right after the request
	else
	begin
		$error("rd_en outside the cycle after fetch_start");
		err_count++;
	end

	// The first bad command stops the run on the next edge
	error_stop: assert property (@(posedge clk) disable iff (!rst)
		(busy && fetch_done && cmd_err != err_none) |=> (!busy && done))
	else
	begin
		$error("run kept going after a command error");
		err_count++;
	end

	read_hold: assert property (@(posedge clk) disable iff (!rst)
		(rvalid && !rready) |=> (rvalid && $stable(rdata)))
	else
	begin
		$error("read data changed while waiting on rready");
		err_count++;
	end

endmodule

bind cmd_proc_top cmd_proc_sva u_cmd_proc_sva (
	.clk(clk), .rst(rst),
	.fetch_start(fetch_start), .fetch_done(fetch_done), .rd_en(rd_en),
	.busy(busy), .done(done), .cmd_err(cmd_err),
	.rvalid(rvalid), .rready(rready), .rdata(rdata)
);

`default_nettype wire

/* test/cmd_proc_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_proc_tb
	import cmd_pkg::*;
();

	logic clk;
	logic rst;
	logic [AXI_AW-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [AXI_DW-1:0] wdata;
	logic wvalid;
	logic wready;
	logic bvalid;
	logic [1:0] bresp;
	logic bready;
	logic [AXI_AW-1:0] araddr;
	logic arvalid;
	logic arready;
	logic rvalid;
	logic [AXI_DW-1:0] rdata;
	logic [1:0] rresp;
	logic rready;

	logic [CMD_W-1:0] prog [BUF_DEPTH]; // Copy of what the host wrote into the buffer
	logic [REG_W-1:0] model_regs [NUM_REGS];
	int unsigned cycles = 0;

	cmd_proc_top u_cmd_proc_top (.*);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic stop_with(input string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else
			stop_with($sformatf("[FAIL] t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp));
	endtask

	// Runs are short, so 20000 cycles leaves a wide margin
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= 20000)
			stop_with("Timeout: the cycle limit was reached before the tests ended");
		else if (u_cmd_proc_top.u_cmd_proc_sva.err_count != 0)
			stop_with("A bound timing assertion failed");
	end

	task automatic axi_write(input logic [AXI_AW-1:0] addr, input logic [AXI_DW-1:0] data);
		int hold;
		hold = $urandom % 4;
		@(negedge clk);
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		#1;
		while (!awready)
		begin
			@(negedge clk);
			#1;
		end
		expect_eq("wready", wready, 1); // Both channels are taken in the same cycle
		@(negedge clk);
		awvalid = 1'b0;
		wvalid = 1'b0;
		repeat (hold)
		begin
			#1;
			expect_eq("bvalid", bvalid, 1); // Response waits for bready
			@(negedge clk);
		end
		bready = 1'b1;
		#1;
		expect_eq("bvalid", bvalid, 1);
		expect_eq("bresp", bresp, 0);
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [AXI_AW-1:0] addr, output logic [AXI_DW-1:0] data);
		int hold;
		hold = $urandom % 4;
		@(negedge clk);
		araddr = addr;
		arvalid = 1'b1;
		#1;
		while (!arready)
		begin
			@(negedge clk);
			#1;
		end
		@(negedge clk);
		arvalid = 1'b0;
		#1;
		data = rdata;
		repeat (hold)
		begin
			@(negedge clk);
			#1;
			expect_eq("rvalid", rvalid, 1);
			expect_eq("rdata", rdata, data);
		end
		@(negedge clk);
		rready = 1'b1;
		#1;
		expect_eq("rvalid", rvalid, 1);
		expect_eq("rdata", rdata, data);
		expect_eq("rresp", rresp, 0);
		@(negedge clk);
		rready = 1'b0;
	endtask

	task automatic load_word(input int idx, input logic [CMD_W-1:0] word);
		axi_write(ADDR_BUF + 12'(4 * idx), {16'hA5C3, word}); // Upper half is ignored
		prog[idx] = word;
	endtask

	function automatic logic [CMD_W-1:0] rand_valid();
		logic [7:0] op;
		logic [4:0] a2;
		op = 8'($urandom % 3);
		a2 = (op == 8'd0) ? 5'($urandom % 11) : 5'($urandom);
		return {op, 3'($urandom), a2};
	endfunction

	// Opcode table applied to the tb copy of the registers
	task automatic run_model(input int start, input int n, output int exp_exec, output int exp_err);
		logic [7:0] op;
		logic [2:0] a1;
		logic [4:0] a2;
		exp_exec = 0;
		exp_err = err_none;
		for (int i = 0; i < n; i++)
		begin
			{op, a1, a2} = prog[(start + i) % BUF_DEPTH];
			if (op > 8'd3)
			begin
				exp_err = err_opcode;
				break;
			end
			if (op == 8'd0 && a2 > 5'd10)
			begin
				exp_err = err_range;
				break;
			end
			case (op)
				8'd0: model_regs[a1] = 8'(a2);
				8'd1: model_regs[a1] = '0;
				8'd2: model_regs[a1] = model_regs[a1] + 8'(a2);
				default: ;
			endcase
			exp_exec++;
			if (op == 8'd3)
				break;
		end
	endtask

	task automatic start_and_check(input int start, input int n, input bit poke_busy);
		logic [AXI_DW-1:0] rd;
		int exp_exec;
		int exp_err;
		int polls;
		axi_write(ADDR_START, start);
		axi_write(ADDR_COUNT, n);
		axi_read(ADDR_START, rd);
		expect_eq("START", rd, start);
		axi_read(ADDR_COUNT, rd);
		expect_eq("COUNT", rd, n);
		axi_write(ADDR_CTRL, 1);
		if (poke_busy)
			axi_write(ADDR_CTRL, 1); // Lands mid-run and must be dropped
		polls = 0;
		do
		begin
			axi_read(ADDR_STATUS, rd);
			polls++;
		end
		while (!rd[1] && polls < 200);
		if (!rd[1])
			stop_with("The run did not report done within 200 status polls");
		run_model(start, n, exp_exec, exp_err);
		expect_eq("status.busy", rd[0], 0);
		expect_eq("status.err", rd[3:2], exp_err);
		expect_eq("status.exec_count", rd[16:8], exp_exec);
		for (int r = 0; r < NUM_REGS; r++)
		begin
			axi_read(ADDR_REGS + 12'(4 * r), rd);
			expect_eq($sformatf("R%0d", r), rd, model_regs[r]);
		end
	endtask

	initial
	begin
		void'($urandom(32'h9799));
		rst = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		for (int r = 0; r < NUM_REGS; r++)
			model_regs[r] = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;

		// R0 is pushed past 255 before the random part
		for (int i = 0; i < 9; i++)
			load_word(i, {8'd2, 3'd0, 5'd31});
		for (int i = 9; i < 40; i++)
			load_word(i, rand_valid());
		start_and_check(0, 40, 1'b1);

		// Range error on the word where the pointer wraps to 0
		for (int i = 0; i < 10; i++)
			load_word((252 + i) % BUF_DEPTH, rand_valid());
		load_word(0, {8'd0, 3'($urandom), 5'(11 + $urandom % 21)});
		start_and_check(252, 10, 1'b0);

		for (int i = 128; i < 138; i++)
			load_word(i, rand_valid());
		load_word(131, {8'(4 + $urandom % 252), 8'($urandom)});
		start_and_check(128, 10, 1'b0);

		// Halt arguments are random and have no effect
		for (int i = 200; i < 208; i++)
			load_word(i, rand_valid());
		load_word(202, {8'd3, 8'($urandom)});
		start_and_check(200, 8, 1'b0);

		start_and_check(0, 0, 1'b0);

		repeat (4) @(negedge clk);
		if (u_cmd_proc_top.u_cmd_proc_sva.err_count == 0)
		begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
		else
			stop_with("A bound timing assertion failed");
	end

endmodule

`default_nettype wire

/* sources.f */
rtl/cmd_pkg.sv
rtl/cmd_buffer.sv
rtl/cmd_fetch_fsm.sv
rtl/cmd_sequencer.sv
rtl/axil_cmd_regs.sv
rtl/cmd_proc_top.sv
test/cmd_proc_sva.sv
test/cmd_proc_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the command processor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module cmd_proc_tb -f sources.f -o cmd_proc_sim

./obj_dir/cmd_proc_sim | tee sim.log

grep -q "ALL CHECKS PASSED" sim.log
echo "Simulation passed"
